/* src/sd_cmd_macros.svh */
`ifndef SD_CMD_MACROS_SVH
`define SD_CMD_MACROS_SVH

// host command frame, start bit to end bit
`define SD_CMD_BITS 48

// R2 frame carrying CID or CSD
`define SD_LONG_RESP_BITS 136

// width of the command line CRC
`define SD_CRC7_BITS 7

// first CRC bit of a 48-bit response, counted from the start bit
`define SD_SHORT_CRC_POS 40

// first CRC bit of an R2 response
`define SD_LONG_CRC_POS 128

// start, transmission and reserved bits of R2 are outside its CRC
`define SD_LONG_CRC_SKIP 8

// clocks to wait once the host lets the line go high after power-up
// (spec asks hosts for 74, some send far fewer)
`define SD_INIT_CLOCKS 60

`endif

/* src/sd_cmd_pkg.sv */
package sd_cmd_pkg;

`include "sd_cmd_macros.svh"

   // command as seen on the line, bit 47 is the start bit
   typedef logic [`SD_CMD_BITS-1:0] sd_cmd_t;

   // response payload, left-aligned
   // short responses use the upper 40 bits
   typedef logic [`SD_LONG_RESP_BITS-1:0] sd_resp_t;

   typedef logic [`SD_CRC7_BITS-1:0] crc7_t;

   typedef enum logic [2:0] {
      RESP_R1  = 3'd0,
      RESP_R1B = 3'd1,
      RESP_R2  = 3'd2,
      RESP_R3  = 3'd3,
      RESP_R6  = 3'd4,
      RESP_R7  = 3'd5
   } resp_type_e;

   typedef enum logic [2:0] {
      RX_RESET     = 3'd0,
      RX_INIT_WAIT = 3'd1,
      RX_IDLE      = 3'd2,
      RX_READ      = 3'd3,
      RX_CHECK     = 3'd4
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE     = 2'd0,
      TX_PREAMBLE = 2'd1,
      TX_WRITE    = 2'd2,
      TX_END      = 2'd3
   } tx_state_e;

   // one bit of x^7 + x^3 + 1, register shifted MSB first
   function automatic crc7_t crc7_step(input crc7_t crc, input logic bit_in);
      logic fb;
      fb = crc[6] ^ bit_in;
      return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
   endfunction

endpackage

/* src/sd_cmd_rx.sv */
`timescale 1ns/1ps

`include "sd_cmd_macros.svh"

module sd_cmd_rx import sd_cmd_pkg::*; (
   input  logic    sd_clk,
   input  logic    reset_n,

   input  logic    sd_cmd_i,
   input  logic    cmd_oe_i,
   input  logic    crc_disable_i,

   output sd_cmd_t cmd_o,
   output logic    cmd_crc_ok_o,
   output logic    cmd_valid_o
);

   rx_state_e state_q;
   logic [5:0] bit_cnt_q;
   logic line_last_q;
   logic start_bit;

   // bits 47..1 of the frame once the last one arrives
   logic [`SD_CMD_BITS-2:0] shift_q;
   crc7_t crc_q;

   // falling edge on the line while we are not driving it
   assign start_bit = line_last_q & ~sd_cmd_i & ~cmd_oe_i;

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q      <= RX_RESET;
         bit_cnt_q    <= '0;
         line_last_q  <= 1'b0;
         cmd_crc_ok_o <= 1'b0;
         cmd_valid_o  <= 1'b0;
      end else begin
         line_last_q <= sd_cmd_i;
         cmd_valid_o <= 1'b0;

         case (state_q)
            RX_RESET: begin
               // host releases the line high before the power-up clocks
               if (sd_cmd_i) begin
                  bit_cnt_q <= '0;
                  state_q   <= RX_INIT_WAIT;
               end
            end
            RX_INIT_WAIT: begin
               bit_cnt_q <= bit_cnt_q + 6'd1;
               if (bit_cnt_q == 6'(`SD_INIT_CLOCKS)) begin
                  state_q <= RX_IDLE;
               end
            end
            RX_IDLE: begin
               if (start_bit) begin
                  bit_cnt_q <= '0;
                  state_q   <= RX_READ;
               end
            end
            RX_READ: begin
               bit_cnt_q <= bit_cnt_q + 6'd1;
               // counter 45 is the edge that samples bit 1
               if (bit_cnt_q == 6'(`SD_CMD_BITS - 3)) begin
                  state_q <= RX_CHECK;
               end
            end
            RX_CHECK: begin
               // this edge samples the end bit
               cmd_crc_ok_o <= crc_disable_i | (shift_q[`SD_CRC7_BITS-1:0] == crc_q);
               // drop frames with transmission bit 0, those came from a card
               cmd_valid_o  <= shift_q[`SD_CMD_BITS-3];
               state_q      <= RX_IDLE;
            end
            default: begin
               state_q <= RX_RESET;
            end
         endcase
      end
   end

   // frame payload and CRC accumulation
   always_ff @(posedge sd_clk) begin
      case (state_q)
         RX_IDLE: begin
            if (start_bit) begin
               // start bit is zero and leaves a cleared CRC unchanged
               shift_q <= '0;
               crc_q   <= '0;
            end
         end
         RX_READ: begin
            shift_q <= {shift_q[`SD_CMD_BITS-3:0], sd_cmd_i};
            // CRC covers bits 46 down to 8
            if (bit_cnt_q < 6'(`SD_CMD_BITS - `SD_CRC7_BITS - 2)) begin
               crc_q <= crc7_step(crc_q, sd_cmd_i);
            end
         end
         RX_CHECK: begin
            cmd_o <= {shift_q, sd_cmd_i};
         end
         default: begin
         end
      endcase
   end

endmodule

/* src/sd_resp_tx.sv */
`timescale 1ns/1ps

`include "sd_cmd_macros.svh"

module sd_resp_tx import sd_cmd_pkg::*; (
   input  logic       sd_clk,
   input  logic       reset_n,

   input  logic       resp_start_i,
   input  resp_type_e resp_type_i,
   input  sd_resp_t   resp_i,

   output logic       sd_cmd_o,
   output logic       sd_cmd_oe_o,
   output logic       resp_busy_o,
   output logic       resp_done_o
);

   tx_state_e state_q;
   logic [7:0] bit_cnt_q;

   // latched response, shifted out from the top and refilled with ones
   sd_resp_t   shift_q;
   resp_type_e type_q;
   crc7_t      crc_q;
   logic       bit_q;

   logic is_r2;
   logic is_r3;
   logic [7:0] last_cnt;
   logic [7:0] crc_pos_cnt;
   logic [7:0] crc_first_cnt;

   assign is_r2 = (type_q == RESP_R2);
   assign is_r3 = (type_q == RESP_R3);

   // frame length and CRC window per response kind
   always_comb begin
      if (is_r2) begin
         last_cnt      = 8'(`SD_LONG_RESP_BITS - 1);
         crc_pos_cnt   = 8'(`SD_LONG_CRC_POS);
         crc_first_cnt = 8'(`SD_LONG_CRC_SKIP);
      end else begin
         last_cnt      = 8'(`SD_CMD_BITS - 1);
         crc_pos_cnt   = 8'(`SD_SHORT_CRC_POS);
         crc_first_cnt = 8'd0;
      end
   end

   // line idles high when released
   assign sd_cmd_o = sd_cmd_oe_o ? bit_q : 1'b1;

   always_ff @(negedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q     <= TX_IDLE;
         bit_cnt_q   <= '0;
         sd_cmd_oe_o <= 1'b0;
         resp_busy_o <= 1'b0;
         resp_done_o <= 1'b0;
      end else begin
         resp_done_o <= 1'b0;

         case (state_q)
            TX_IDLE: begin
               // a strobe outside idle is simply not looked at
               if (resp_start_i) begin
                  resp_busy_o <= 1'b1;
                  state_q     <= TX_PREAMBLE;
               end
            end
            TX_PREAMBLE: begin
               bit_cnt_q <= '0;
               state_q   <= TX_WRITE;
            end
            TX_WRITE: begin
               sd_cmd_oe_o <= 1'b1;
               bit_cnt_q   <= bit_cnt_q + 8'd1;
               if (bit_cnt_q == last_cnt) begin
                  state_q <= TX_END;
               end
            end
            TX_END: begin
               sd_cmd_oe_o <= 1'b0;
               resp_busy_o <= 1'b0;
               resp_done_o <= 1'b1;
               state_q     <= TX_IDLE;
            end
            default: begin
               state_q <= TX_IDLE;
            end
         endcase
      end
   end

   // serializer datapath
   always_ff @(negedge sd_clk) begin
      case (state_q)
         TX_IDLE: begin
            if (resp_start_i) begin
               shift_q <= resp_i;
               type_q  <= resp_type_i;
               crc_q   <= '0;
            end
         end
         TX_WRITE: begin
            shift_q <= {shift_q[`SD_LONG_RESP_BITS-2:0], 1'b1};
            if (bit_cnt_q < crc_pos_cnt) begin
               bit_q <= shift_q[`SD_LONG_RESP_BITS-1];
               // R2 leaves its first 8 bits out of the CRC
               if (bit_cnt_q >= crc_first_cnt) begin
                  crc_q <= crc7_step(crc_q, shift_q[`SD_LONG_RESP_BITS-1]);
               end
            end else begin
               // CRC MSB first, the refill ones give the end bit
               // R3 sends ones in place of a CRC
               bit_q <= crc_q[`SD_CRC7_BITS-1] | is_r3;
               crc_q <= {crc_q[`SD_CRC7_BITS-2:0], 1'b1};
            end
         end
         default: begin
         end
      endcase
   end

endmodule

/* src/sd_cmd_phy.sv */
`timescale 1ns/1ps

module sd_cmd_phy import sd_cmd_pkg::*; (
   input  logic       sd_clk,
   input  logic       reset_n,

   input  logic       sd_cmd_i,
   input  logic       crc_disable_i,
   input  logic       resp_start_i,
   input  resp_type_e resp_type_i,
   input  sd_resp_t   resp_i,

   output logic       sd_cmd_o,
   output logic       sd_cmd_oe_o,
   output sd_cmd_t    cmd_o,
   output logic       cmd_crc_ok_o,
   output logic       cmd_valid_o,
   output logic       resp_busy_o,
   output logic       resp_done_o
);

   // receiver, rising edges of sd_clk
   // our own output enable masks the line while we answer
   sd_cmd_rx sd_cmd_rx_i (
      .sd_clk        (sd_clk),
      .reset_n       (reset_n),
      .sd_cmd_i      (sd_cmd_i),
      .cmd_oe_i      (sd_cmd_oe_o),
      .crc_disable_i (crc_disable_i),
      .cmd_o         (cmd_o),
      .cmd_crc_ok_o  (cmd_crc_ok_o),
      .cmd_valid_o   (cmd_valid_o)
   );

   // transmitter, falling edges of sd_clk
   sd_resp_tx sd_resp_tx_i (
      .sd_clk       (sd_clk),
      .reset_n      (reset_n),
      .resp_start_i (resp_start_i),
      .resp_type_i  (resp_type_i),
      .resp_i       (resp_i),
      .sd_cmd_o     (sd_cmd_o),
      .sd_cmd_oe_o  (sd_cmd_oe_o),
      .resp_busy_o  (resp_busy_o),
      .resp_done_o  (resp_done_o)
   );

endmodule

/* test/sd_host_tasks.svh */
`ifndef SD_HOST_TASKS_SVH
`define SD_HOST_TASKS_SVH

// CRC7 over bits 47 down to 8 of a command
function automatic crc7_t crc7_of_cmd(input sd_cmd_t frame);
   crc7_t crc;
   crc = '0;
   for (int i = `SD_CMD_BITS-1; i > `SD_CRC7_BITS; i--) begin
      crc = crc7_step(crc, frame[i]);
   end
   return crc;
endfunction

function automatic sd_cmd_t build_cmd(input logic tx, input logic [5:0] idx,
                                      input logic [31:0] arg);
   sd_cmd_t frame;
   frame = {1'b0, tx, idx, arg, 7'd0, 1'b1};
   frame[`SD_CRC7_BITS:1] = crc7_of_cmd(frame);
   return frame;
endfunction

function automatic sd_resp_t random_resp();
   sd_resp_t r;
   r = {$urandom(), $urandom(), $urandom(), $urandom(), 8'($urandom())};
   // start and transmission bits as a card sends them
   r[`SD_LONG_RESP_BITS-1 -: 2] = 2'b00;
   return r;
endfunction

task automatic idle_cycles(input int n);
   repeat (n) @(posedge sd_clk);
   #1;
endtask

// host drives one command, then opens the one-cycle check window
task automatic send_frame(input sd_cmd_t frame);
   exp_cmd    = frame;
   exp_valid  = frame[`SD_CMD_BITS-2];
   exp_crc_ok = crc_disable_i || (frame[`SD_CRC7_BITS:1] == crc7_of_cmd(frame));
   for (int i = `SD_CMD_BITS-1; i >= 0; i--) begin
      @(posedge sd_clk);
      #1;
      sd_cmd_i = frame[i];
   end
   @(posedge sd_clk);
   #1;
   sd_cmd_i  = 1'b1;
   check_cmd = 1'b1;
   @(posedge sd_clk);
   #1;
   check_cmd = 1'b0;
endtask

// noisy drives random lows while the card owns the line,
// restrobe fires a second strobe mid-frame
task automatic send_response(input resp_type_e t, input sd_resp_t r,
                             input logic noisy, input logic restrobe);
   crc7_t crc;
   int unsigned n;
   int cycles;
   logic done;
   n = (t == RESP_R2) ? `SD_LONG_RESP_BITS : `SD_CMD_BITS;
   crc = '0;
   exp_line = '1;
   for (int k = 0; k < n - `SD_CRC7_BITS - 1; k++) begin
      exp_line[k] = r[`SD_LONG_RESP_BITS-1-k];
      if (t != RESP_R2 || k >= `SD_LONG_CRC_SKIP) begin
         crc = crc7_step(crc, r[`SD_LONG_RESP_BITS-1-k]);
      end
   end
   if (t == RESP_R3) begin
      crc = '1;
   end
   for (int k = 0; k < `SD_CRC7_BITS; k++) begin
      exp_line[n - `SD_CRC7_BITS - 1 + k] = crc[`SD_CRC7_BITS-1-k];
   end
   exp_len = n;
   @(posedge sd_clk);
   #1;
   resp_start_i = 1'b1;
   resp_type_i  = t;
   resp_i       = r;
   tx_arm       = 1'b1;
   cycles = 0;
   done = 1'b0;
   while (!done && cycles < RESP_TIMEOUT) begin
      @(posedge sd_clk);
      #1;
      cycles++;
      tx_arm = 1'b0;
      resp_start_i = 1'b0;
      if (resp_done_o) begin
         done = 1'b1;
      end
      if (noisy) begin
         sd_cmd_i = (sd_cmd_oe_o && tx_idx < exp_len - 1) ? 1'($urandom()) : 1'b1;
      end
      if (restrobe && cycles == 20) begin
         resp_start_i = 1'b1;
         resp_type_i  = RESP_R2;
         resp_i       = ~r;
      end
   end
   sd_cmd_i = 1'b1;
   if (!done) begin
      $display("response %s never signalled done within %0d cycles", t.name(), RESP_TIMEOUT);
      error_count++;
   end
   idle_cycles(2);
endtask

task automatic begin_test();
   errors_at_start = error_count;
endtask

task automatic finish_test(input string name);
   if (error_count == errors_at_start) begin
      $display("test %s: passed", name);
      pass_count++;
   end else begin
      $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
      fail_count++;
   end
endtask

`endif

/* test/tb_sd_cmd_phy.sv */
`timescale 1ns/1ps

`include "sd_cmd_macros.svh"

module tb_sd_cmd_phy import sd_cmd_pkg::*; ();

   localparam int CLK_PERIOD   = 8;
   localparam int NUM_CMDS     = 7;
   localparam int NUM_SHORT    = 8;
   localparam int NUM_LONG     = 2;
   localparam int RESP_TIMEOUT = 2 * `SD_LONG_RESP_BITS + 20;
   localparam int WATCHDOG_CYCLES = 20 * (NUM_CMDS * `SD_CMD_BITS
      + NUM_SHORT * `SD_CMD_BITS + NUM_LONG * `SD_LONG_RESP_BITS);

   logic       sd_clk = 1'b0;
   logic       reset_n;
   logic       sd_cmd_i;
   logic       crc_disable_i;
   logic       resp_start_i;
   resp_type_e resp_type_i;
   sd_resp_t   resp_i;
   logic       sd_cmd_o;
   logic       sd_cmd_oe_o;
   sd_cmd_t    cmd_o;
   logic       cmd_crc_ok_o;
   logic       cmd_valid_o;
   logic       resp_busy_o;
   logic       resp_done_o;

   // host model state seen by the assertions
   logic       check_cmd;
   logic       exp_valid;
   logic       exp_crc_ok;
   sd_cmd_t    exp_cmd;
   logic [`SD_LONG_RESP_BITS-1:0] exp_line;
   int unsigned exp_len;
   logic       tx_arm;
   int unsigned tx_idx;
   logic       exp_bit;

   int error_count = 0;
   int pass_count = 0;
   int fail_count = 0;
   int errors_at_start;

   always #(CLK_PERIOD / 2) sd_clk = ~sd_clk;

   sd_cmd_phy sd_cmd_phy_i (
      .sd_clk        (sd_clk),
      .reset_n       (reset_n),
      .sd_cmd_i      (sd_cmd_i),
      .crc_disable_i (crc_disable_i),
      .resp_start_i  (resp_start_i),
      .resp_type_i   (resp_type_i),
      .resp_i        (resp_i),
      .sd_cmd_o      (sd_cmd_o),
      .sd_cmd_oe_o   (sd_cmd_oe_o),
      .cmd_o         (cmd_o),
      .cmd_crc_ok_o  (cmd_crc_ok_o),
      .cmd_valid_o   (cmd_valid_o),
      .resp_busy_o   (resp_busy_o),
      .resp_done_o   (resp_done_o)
   );

   // index of the response bit the card drives right now
   always @(posedge sd_clk) begin
      if (tx_arm) begin
         tx_idx <= 0;
      end else if (sd_cmd_oe_o) begin
         tx_idx <= tx_idx + 1;
      end
   end

   assign exp_bit = exp_line[tx_idx];

   `include "sd_host_tasks.svh"

   // receiver checks with one window per sent frame
   valid_only_when_expected: assert property (@(posedge sd_clk) disable iff (!reset_n)
      cmd_valid_o |-> (check_cmd && exp_valid))
      else begin
         $display("Fail %0t cmd_valid_o expected 0 got 1", $time);
         error_count++;
      end
   valid_in_window: assert property (@(posedge sd_clk) disable iff (!reset_n)
      check_cmd |-> (cmd_valid_o == exp_valid))
      else begin
         $display("Fail %0t cmd_valid_o expected %b got %b", $time,
                  $sampled(exp_valid), $sampled(cmd_valid_o));
         error_count++;
      end
   crc_ok_in_window: assert property (@(posedge sd_clk) disable iff (!reset_n)
      check_cmd |-> (cmd_crc_ok_o == exp_crc_ok))
      else begin
         $display("Fail %0t cmd_crc_ok_o expected %b got %b", $time,
                  $sampled(exp_crc_ok), $sampled(cmd_crc_ok_o));
         error_count++;
      end
   cmd_word_in_window: assert property (@(posedge sd_clk) disable iff (!reset_n)
      (check_cmd && exp_valid) |-> (cmd_o == exp_cmd))
      else begin
         $display("Fail %0t cmd_o expected %h got %h", $time,
                  $sampled(exp_cmd), $sampled(cmd_o));
         error_count++;
      end

   // transmitter checks sampled mid-bit on rising edges
   resp_bit_value: assert property (@(posedge sd_clk) disable iff (!reset_n)
      sd_cmd_oe_o |-> (sd_cmd_o == exp_bit))
      else begin
         $display("Fail %0t sd_cmd_o bit %0d expected %b got %b", $time,
                  $sampled(tx_idx), $sampled(exp_bit), $sampled(sd_cmd_o));
         error_count++;
      end
   resp_no_overrun: assert property (@(posedge sd_clk) disable iff (!reset_n)
      sd_cmd_oe_o |-> (tx_idx < exp_len))
      else begin
         $display("Fail %0t sd_cmd_oe_o expected 0 got 1", $time);
         error_count++;
      end
   line_high_when_released: assert property (@(posedge sd_clk) disable iff (!reset_n)
      !sd_cmd_oe_o |-> sd_cmd_o)
      else begin
         $display("Fail %0t sd_cmd_o expected 1 got 0", $time);
         error_count++;
      end
   busy_while_sending: assert property (@(posedge sd_clk) disable iff (!reset_n)
      (tx_arm || sd_cmd_oe_o) |-> resp_busy_o)
      else begin
         $display("Fail %0t resp_busy_o expected 1 got 0", $time);
         error_count++;
      end
   resp_length: assert property (@(posedge sd_clk) disable iff (!reset_n)
      resp_done_o |-> (tx_idx == exp_len))
      else begin
         $display("Fail %0t sd_cmd_o bit count expected %0d got %0d", $time,
                  $sampled(exp_len), $sampled(tx_idx));
         error_count++;
      end
   busy_low_at_done: assert property (@(posedge sd_clk) disable iff (!reset_n)
      resp_done_o |-> !resp_busy_o)
      else begin
         $display("Fail %0t resp_busy_o expected 0 got 1", $time);
         error_count++;
      end
   done_single_pulse: assert property (@(posedge sd_clk) disable iff (!reset_n)
      resp_done_o |-> !$past(resp_done_o))
      else begin
         $display("Fail %0t resp_done_o expected 0 got 1", $time);
         error_count++;
      end
   busy_only_after_strobe: assert property (@(posedge sd_clk) disable iff (!reset_n)
      $rose(resp_busy_o) |-> tx_arm)
      else begin
         $display("a response started at %0t without an accepted strobe", $time);
         error_count++;
      end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      sd_cmd_t frame;

      void'($urandom(32'h8f0bdc4c));
      reset_n       = 1'b0;
      sd_cmd_i      = 1'b1;
      crc_disable_i = 1'b0;
      resp_start_i  = 1'b0;
      resp_type_i   = RESP_R1;
      resp_i        = '0;
      check_cmd     = 1'b0;
      exp_valid     = 1'b0;
      exp_crc_ok    = 1'b0;
      exp_cmd       = '0;
      exp_line      = '1;
      exp_len       = 0;
      tx_arm        = 1'b0;
      repeat (8) @(posedge sd_clk);
      #1;
      reset_n = 1'b1;
      // power-up clocks with the line high
      idle_cycles(80);

      begin_test();
      repeat (4) begin
         send_frame(build_cmd(1'b1, 6'($urandom()), $urandom()));
         idle_cycles(3);
      end
      finish_test("command capture");

      begin_test();
      frame = build_cmd(1'b1, 6'($urandom()), $urandom());
      frame[4] = ~frame[4];
      send_frame(frame);
      idle_cycles(3);
      crc_disable_i = 1'b1;
      send_frame(frame);
      idle_cycles(3);
      crc_disable_i = 1'b0;
      finish_test("command crc error and crc disable");

      begin_test();
      send_frame(build_cmd(1'b0, 6'($urandom()), $urandom()));
      idle_cycles(3);
      finish_test("transmission bit zero");

      begin_test();
      send_response(RESP_R1, random_resp(), 1'b0, 1'b0);
      send_response(RESP_R7, random_resp(), 1'b0, 1'b0);
      send_response(RESP_R1, random_resp(), 1'b0, 1'b0);
      send_response(RESP_R7, random_resp(), 1'b0, 1'b0);
      send_response(RESP_R3, random_resp(), 1'b0, 1'b0);
      send_response(RESP_R1B, random_resp(), 1'b0, 1'b0);
      send_response(RESP_R6, random_resp(), 1'b0, 1'b0);
      finish_test("short responses");

      begin_test();
      send_response(RESP_R2, random_resp(), 1'b0, 1'b0);
      finish_test("long response");

      begin_test();
      send_response(RESP_R1, random_resp(), 1'b1, 1'b1);
      send_response(RESP_R2, random_resp(), 1'b1, 1'b1);
      finish_test("strobe while busy and line noise");

      $display("tests passed: %0d, tests failed: %0d, errors: %0d",
               pass_count, fail_count, error_count);
      if (error_count == 0 && fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* src.f */
+incdir+src
+incdir+test
src/sd_cmd_pkg.sv
src/sd_cmd_rx.sv
src/sd_resp_tx.sv
src/sd_cmd_phy.sv
test/tb_sd_cmd_phy.sv

/* Bender.yml */
package:
  name: sd_cmd_phy

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/sd_cmd_pkg.sv
      - src/sd_cmd_rx.sv
      - src/sd_resp_tx.sv
      - src/sd_cmd_phy.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/tb_sd_cmd_phy.sv
